// ==== logic/bp_cfg_pkg.sv ====
// predictor sizes; pht_entries must equal 2**ghr_bits and btb_entries must equal 2**btb_idx_bits
`default_nettype none

package bp_cfg_pkg;

  // fetch address, word addressed
  localparam int pc_msb = 31;
  localparam int pc_lsb = 2;

  // gshare history and counter table
  localparam int ghr_bits    = 14;
  localparam int pht_entries = 16384;
  localparam int pht_idx_lsb = 3;
  localparam int pht_idx_msb = pht_idx_lsb + ghr_bits - 1;

  // direct-mapped target buffer, index 7:2 and partial tag 15:8
  localparam int btb_entries  = 64;
  localparam int btb_idx_bits = 6;
  localparam int btb_tag_bits = 8;
  localparam int btb_idx_lsb  = pc_lsb;
  localparam int btb_idx_msb  = btb_idx_lsb + btb_idx_bits - 1;
  localparam int btb_tag_lsb  = btb_idx_msb + 1;
  localparam int btb_tag_msb  = btb_tag_lsb + btb_tag_bits - 1;

endpackage

`default_nettype wire

// ==== logic/bp_types_pkg.sv ====
// tag and entry layouts; the prediction tag is exactly 16 bits only while ghr_bits is 14
`default_nettype none

package bp_types_pkg;

  // two-bit saturating counter, msb is the predicted direction
  typedef enum logic [1:0] {
    ctr_snt = 2'd0,
    ctr_wnt = 2'd1,
    ctr_wt  = 2'd2,
    ctr_st  = 2'd3
  } ctr_t;

  // handed to fetch with each prediction and returned by the rob at retire
  typedef struct packed {
    ctr_t                            ctr;
    logic [bp_cfg_pkg::ghr_bits-1:0] idx;
  } bp_tag_t;

  // target buffer payload, valid bits are kept apart
  typedef struct packed {
    logic [bp_cfg_pkg::btb_tag_bits-1:0]           tag;
    logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] target;
  } btb_data_t;

  // step a counter toward the resolved direction
  function automatic ctr_t ctr_update(input ctr_t ctr, input logic taken);
    ctr_t nxt;
    case (ctr)
      ctr_snt: nxt = taken ? ctr_wnt : ctr_snt;
      ctr_wnt: nxt = taken ? ctr_wt  : ctr_snt;
      ctr_wt:  nxt = taken ? ctr_st  : ctr_wnt;
      default: nxt = taken ? ctr_st  : ctr_wt;
    endcase
    return nxt;
  endfunction

endpackage

`default_nettype wire

// ==== logic/bp_gshare.sv ====
// gshare direction predictor; counter table has no reset and is zeroed only at simulation start
`timescale 1ns/1ps
`default_nettype none

module bp_gshare (
  input  logic                                         clk,
  input  logic                                         rst,

  // fetch side
  input  logic                                         fetch_req,
  input  logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] fetch_pc,
  output logic                                         pred_taken,
  output bp_types_pkg::bp_tag_t                        pred_tag,

  // retire side
  input  logic                                         rob_flush,
  input  logic                                         rob_ret_branch,
  input  bp_types_pkg::bp_tag_t                        rob_ret_tag,
  input  logic                                         rob_ret_taken
);

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  typedef logic [ghr_bits-1:0] hist_t;

  // counter table
  ctr_t  pht [pht_entries];

  // a prediction was delivered in this cycle
  logic  pred_vld_r;

  hist_t spec_ghr;
  hist_t arch_ghr;
  hist_t spec_ghr_next;
  hist_t arch_ghr_next;

  hist_t rd_idx;
  hist_t rd_idx_r;
  ctr_t  rd_ctr_r;
  ctr_t  wr_ctr;

  // histories with the newest outcome shifted in at the lsb
  assign spec_ghr_next = {spec_ghr[ghr_bits-2:0], pred_taken};
  assign arch_ghr_next = {arch_ghr[ghr_bits-2:0], rob_ret_taken};

  // back-to-back requests see the history already shifted by the
  // prediction that is on the outputs right now
  assign rd_idx = (pred_vld_r ? spec_ghr_next : spec_ghr) ^
                  fetch_pc[pht_idx_msb:pht_idx_lsb];

  // the tag carries the old counter, so retire needs no table read
  assign wr_ctr = ctr_update(rob_ret_tag.ctr, rob_ret_taken);

  assign pred_tag.ctr = rd_ctr_r;
  assign pred_tag.idx = rd_idx_r;
  assign pred_taken   = rd_ctr_r[1];

  initial begin
    for (int i = 0; i < pht_entries; i++) begin
      pht[i] = ctr_snt;
    end
  end

  // one read port and one write port, a read on the write edge gets the old value
  always @(posedge clk) begin
    if (fetch_req) begin
      rd_ctr_r <= pht[rd_idx];
      rd_idx_r <= rd_idx;
    end
    if (rob_ret_branch) begin
      pht[rob_ret_tag.idx] <= wr_ctr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pred_vld_r <= 1'b0;
    end else begin
      pred_vld_r <= fetch_req;
    end
  end

  // architectural history follows retired branches only
  always_ff @(posedge clk) begin
    if (rst) begin
      arch_ghr <= '0;
    end else if (rob_ret_branch) begin
      arch_ghr <= arch_ghr_next;
    end
  end

  // speculative history, restored from the retired state on a flush
  always_ff @(posedge clk) begin
    if (rst) begin
      spec_ghr <= '0;
    end else if (rob_flush) begin
      spec_ghr <= rob_ret_branch ? arch_ghr_next : arch_ghr;
    end else if (pred_vld_r) begin
      spec_ghr <= spec_ghr_next;
    end
  end

endmodule

`default_nettype wire

// ==== logic/bp_btb.sv ====
// direct-mapped target buffer; partial tags allow false hits between pcs that share bits 15:2
`timescale 1ns/1ps
`default_nettype none

module bp_btb (
  input  logic                                         clk,
  input  logic                                         rst,

  // fetch side
  input  logic                                         fetch_req,
  input  logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] fetch_pc,
  output logic                                         pred_hit,
  output logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] pred_target,

  // retire side
  input  logic                                         rob_ret_branch,
  input  logic                                         rob_ret_taken,
  input  logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] rob_ret_pc,
  input  logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] rob_ret_target
);

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  typedef logic [btb_idx_bits-1:0] btb_idx_t;
  typedef logic [btb_tag_bits-1:0] btb_tag_t;

  // valid bits are flops so reset can clear them all at once
  logic [btb_entries-1:0] valid;
  btb_data_t              data [btb_entries];

  btb_idx_t  rd_idx;
  btb_tag_t  rd_tag;
  btb_idx_t  wr_idx;
  btb_data_t wr_data;
  logic      install;

  // lookup state held until the next request
  logic      rd_valid_r;
  btb_tag_t  rd_tag_r;
  btb_data_t rd_data_r;

  assign rd_idx = fetch_pc[btb_idx_msb:btb_idx_lsb];
  assign rd_tag = fetch_pc[btb_tag_msb:btb_tag_lsb];

  assign wr_idx         = rob_ret_pc[btb_idx_msb:btb_idx_lsb];
  assign wr_data.tag    = rob_ret_pc[btb_tag_msb:btb_tag_lsb];
  assign wr_data.target = rob_ret_target;

  // only taken branches are worth a target
  assign install = rob_ret_branch && rob_ret_taken;

  // tag compare after the read register
  assign pred_hit    = rd_valid_r && (rd_data_r.tag == rd_tag_r);
  assign pred_target = rd_data_r.target;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (install) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_r <= 1'b0;
    end else if (fetch_req) begin
      rd_valid_r <= valid[rd_idx];
    end
  end

  // payload array, a same-edge read returns the entry before the install
  always_ff @(posedge clk) begin
    if (install) begin
      data[wr_idx] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req) begin
      rd_data_r <= data[rd_idx];
      rd_tag_r  <= rd_tag;
    end
  end

endmodule

`default_nettype wire

// ==== logic/bp_unit.sv ====
// branch predictor top; one request per cycle, answer one cycle later and held until the next
`timescale 1ns/1ps
`default_nettype none

module bp_unit (
  input  logic                                         clk,
  input  logic                                         rst,

  // fetch side
  input  logic                                         fetch_req,
  input  logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] fetch_pc,
  output logic                                         pred_valid,
  output logic                                         pred_taken,
  output bp_types_pkg::bp_tag_t                        pred_tag,
  output logic                                         pred_hit,
  output logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] pred_target,

  // retire side
  input  logic                                         rob_flush,
  input  logic                                         rob_ret_branch,
  input  bp_types_pkg::bp_tag_t                        rob_ret_tag,
  input  logic                                         rob_ret_taken,
  input  logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] rob_ret_pc,
  input  logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] rob_ret_target
);

  // both tables answer with fixed one-cycle latency
  always_ff @(posedge clk) begin
    if (rst) begin
      pred_valid <= 1'b0;
    end else begin
      pred_valid <= fetch_req;
    end
  end

  // direction
  bp_gshare bp_gshare_inst (
    .clk            (clk),
    .rst            (rst),
    .fetch_req      (fetch_req),
    .fetch_pc       (fetch_pc),
    .pred_taken     (pred_taken),
    .pred_tag       (pred_tag),
    .rob_flush      (rob_flush),
    .rob_ret_branch (rob_ret_branch),
    .rob_ret_tag    (rob_ret_tag),
    .rob_ret_taken  (rob_ret_taken)
  );

  // target
  bp_btb bp_btb_inst (
    .clk            (clk),
    .rst            (rst),
    .fetch_req      (fetch_req),
    .fetch_pc       (fetch_pc),
    .pred_hit       (pred_hit),
    .pred_target    (pred_target),
    .rob_ret_branch (rob_ret_branch),
    .rob_ret_taken  (rob_ret_taken),
    .rob_ret_pc     (rob_ret_pc),
    .rob_ret_target (rob_ret_target)
  );

endmodule

`default_nettype wire

// ==== tests/bp_clk_gen.sv ====
// free-running 20 ns clock; rst is high for the first 8 rising edges
`timescale 1ns/1ps
`default_nettype none

module bp_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tests/bp_unit_chk.sv ====
// protocol checks on the predictor outputs; target is only checked while the lookup hits
`timescale 1ns/1ps
`default_nettype none

module bp_unit_chk (
  input logic                                         clk,
  input logic                                         rst,
  input logic                                         fetch_req,
  input logic                                         pred_valid,
  input logic                                         pred_taken,
  input bp_types_pkg::bp_tag_t                        pred_tag,
  input logic                                         pred_hit,
  input logic [bp_cfg_pkg::pc_msb:bp_cfg_pkg::pc_lsb] pred_target
);

  // fixed one-cycle answer
  valid_follows_req: assert property (
    @(posedge clk) disable iff (rst) pred_valid == $past(fetch_req)
  ) else $error("pred_valid does not follow fetch_req by one cycle");

  valid_low_after_reset: assert property (
    @(posedge clk) $fell(rst) |-> !pred_valid
  ) else $error("pred_valid high in the cycle after reset");

  // direction is the counter msb
  taken_is_ctr_msb: assert property (
    @(posedge clk) disable iff (rst) pred_valid |-> (pred_taken == pred_tag[15])
  ) else $error("pred_taken differs from pred_tag bit 15");

  outputs_known: assert property (
    @(posedge clk) disable iff (rst)
      pred_valid |-> !$isunknown({pred_taken, pred_tag, pred_hit})
  ) else $error("prediction outputs unknown while pred_valid is high");

  target_known_on_hit: assert property (
    @(posedge clk) disable iff (rst)
      (pred_valid && pred_hit) |-> !$isunknown(pred_target)
  ) else $error("pred_target unknown on a target buffer hit");

endmodule

bind bp_unit bp_unit_chk bp_unit_chk_inst (
  .clk         (clk),
  .rst         (rst),
  .fetch_req   (fetch_req),
  .pred_valid  (pred_valid),
  .pred_taken  (pred_taken),
  .pred_tag    (pred_tag),
  .pred_hit    (pred_hit),
  .pred_target (pred_target)
);

`default_nettype wire

// ==== tests/bp_unit_tb.sv ====
// self-checking predictor testbench; model assumes a zeroed counter table at time zero
`timescale 1ns/1ps
`default_nettype none

module bp_unit_tb;

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  typedef logic [pc_msb:pc_lsb] pc_t;

  localparam int wait_limit = 20;

  logic    clk;
  logic    rst;
  logic    fetch_req;
  pc_t     fetch_pc;
  logic    pred_valid;
  logic    pred_taken;
  bp_tag_t pred_tag;
  logic    pred_hit;
  pc_t     pred_target;
  logic    rob_flush;
  logic    rob_ret_branch;
  bp_tag_t rob_ret_tag;
  logic    rob_ret_taken;
  pc_t     rob_ret_pc;
  pc_t     rob_ret_target;

  // reference state
  logic [1:0]              pht_m [pht_entries];
  logic [ghr_bits-1:0]     spec_m;
  logic [ghr_bits-1:0]     arch_m;
  logic                    btb_v_m [btb_entries];
  logic [btb_tag_bits-1:0] btb_t_m [btb_entries];
  pc_t                     btb_d_m [btb_entries];

  // expected answer of the latest request
  bp_tag_t exp_tag;
  logic    exp_hit;
  pc_t     exp_target;

  int errors;
  int test_err;
  int tests_ok;
  int tests_bad;

  bp_clk_gen clk_gen_inst (.clk(clk), .rst(rst));

  bp_unit bp_unit_inst (
    .clk            (clk),
    .rst            (rst),
    .fetch_req      (fetch_req),
    .fetch_pc       (fetch_pc),
    .pred_valid     (pred_valid),
    .pred_taken     (pred_taken),
    .pred_tag       (pred_tag),
    .pred_hit       (pred_hit),
    .pred_target    (pred_target),
    .rob_flush      (rob_flush),
    .rob_ret_branch (rob_ret_branch),
    .rob_ret_tag    (rob_ret_tag),
    .rob_ret_taken  (rob_ret_taken),
    .rob_ret_pc     (rob_ret_pc),
    .rob_ret_target (rob_ret_target)
  );

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_err++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_err == 0) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: failed with %0d errors", name, test_err);
      tests_bad++;
    end
    test_err = 0;
  endtask

  function automatic pc_t random_pc();
    logic [31:0] r;
    r = $urandom;
    return r[31:2];
  endfunction

  // expected lookup and the history shifted by the predicted direction
  task automatic model_predict(input pc_t pc);
    logic [btb_idx_bits-1:0] bi;
    bi = pc[btb_idx_msb:btb_idx_lsb];
    exp_tag.idx = spec_m ^ pc[pht_idx_msb:pht_idx_lsb];
    exp_tag.ctr = ctr_t'(pht_m[exp_tag.idx]);
    exp_hit     = btb_v_m[bi] && (btb_t_m[bi] == pc[btb_tag_msb:btb_tag_lsb]);
    exp_target  = btb_d_m[bi];
    spec_m      = {spec_m[ghr_bits-2:0], exp_tag.ctr[1]};
  endtask

  task automatic model_retire(input bp_tag_t tag, input logic taken, input pc_t pc,
                              input pc_t tgt);
    logic [1:0] c;
    c = tag.ctr;
    if (taken && c != 2'd3) begin
      c = c + 2'd1;
    end else if (!taken && c != 2'd0) begin
      c = c - 2'd1;
    end
    pht_m[tag.idx] = c;
    arch_m = {arch_m[ghr_bits-2:0], taken};
    if (taken) begin
      btb_v_m[pc[btb_idx_msb:btb_idx_lsb]] = 1'b1;
      btb_t_m[pc[btb_idx_msb:btb_idx_lsb]] = pc[btb_tag_msb:btb_tag_lsb];
      btb_d_m[pc[btb_idx_msb:btb_idx_lsb]] = tgt;
    end
  endtask

  task automatic check_outputs();
    check_val("pred_valid", 32'(pred_valid), 32'd1);
    check_val("pred_tag", 32'(pred_tag), 32'(exp_tag));
    check_val("pred_taken", 32'(pred_taken), 32'(exp_tag.ctr[1]));
    check_val("pred_hit", 32'(pred_hit), 32'(exp_hit));
    if (exp_hit) begin
      check_val("pred_target", 32'(pred_target), 32'(exp_target));
    end
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!pred_valid && n < wait_limit);
    if (!pred_valid) begin
      $display("timeout: pred_valid never rose after a request");
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  // one cycle of stimulus; a same-edge read sees the state before the retire
  task automatic operate(input logic req, input pc_t pc, input logic ret, input bp_tag_t tag,
                         input logic taken, input pc_t rpc, input pc_t rtgt, input logic flush);
    @(posedge clk);
    fetch_req      <= req;
    fetch_pc       <= pc;
    rob_ret_branch <= ret;
    rob_ret_tag    <= tag;
    rob_ret_taken  <= taken;
    rob_ret_pc     <= rpc;
    rob_ret_target <= rtgt;
    rob_flush      <= flush;
    if (req) begin
      model_predict(pc);
    end
    if (ret) begin
      model_retire(tag, taken, rpc, rtgt);
    end
    if (flush) begin
      spec_m = arch_m;
    end
    @(posedge clk);
    fetch_req      <= 1'b0;
    rob_ret_branch <= 1'b0;
    rob_flush      <= 1'b0;
    if (req) begin
      wait_valid();
      check_outputs();
    end
  endtask

  task automatic predict(input pc_t pc);
    operate(1'b1, pc, 1'b0, '0, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic retire(input bp_tag_t tag, input logic taken, input pc_t pc, input pc_t tgt,
                        input logic flush);
    operate(1'b0, '0, 1'b1, tag, taken, pc, tgt, flush);
  endtask

  task automatic flush_only();
    operate(1'b0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b1);
  endtask

  // address whose gshare index after a flush lands on idx
  function automatic pc_t pc_for_idx(input logic [ghr_bits-1:0] idx, input pc_t base);
    pc_t pc;
    pc = base;
    pc[pht_idx_msb:pht_idx_lsb] = arch_m ^ idx;
    return pc;
  endfunction

  initial begin
    bp_tag_t t;
    pc_t     p1;
    pc_t     p2;
    pc_t     tg;
    int      n;

    fetch_req      = 1'b0;
    fetch_pc       = '0;
    rob_flush      = 1'b0;
    rob_ret_branch = 1'b0;
    rob_ret_tag    = '0;
    rob_ret_taken  = 1'b0;
    rob_ret_pc     = '0;
    rob_ret_target = '0;
    errors = 0;
    test_err = 0;
    tests_ok = 0;
    tests_bad = 0;
    spec_m = '0;
    arch_m = '0;
    for (int i = 0; i < pht_entries; i++) begin
      pht_m[i] = 2'd0;
    end
    for (int i = 0; i < btb_entries; i++) begin
      btb_v_m[i] = 1'b0;
      btb_t_m[i] = '0;
      btb_d_m[i] = '0;
    end
    void'($urandom(32'h61ef2773));

    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (rst && n < wait_limit);
    if (rst) begin
      $display("timeout: reset never released");
      $display("TESTS FAILED");
      $finish;
    end

    // cold tables after reset
    @(negedge clk);
    check_val("pred_valid", 32'(pred_valid), 32'd0);
    predict(random_pc());
    check_val("pred_tag.ctr", 32'(pred_tag.ctr), 32'd0);
    check_val("pred_hit", 32'(pred_hit), 32'd0);
    end_test("after_reset");

    // second index must use the forwarded history
    // a nonzero history first, so the shift is visible
    retire('0, 1'b1, random_pc(), random_pc(), 1'b1);
    p1 = random_pc();
    p2 = random_pc();
    @(posedge clk);
    fetch_req <= 1'b1;
    fetch_pc  <= p1;
    model_predict(p1);
    @(posedge clk);
    fetch_pc  <= p2;
    wait_valid();
    check_outputs();
    model_predict(p2);
    @(posedge clk);
    fetch_req <= 1'b0;
    @(negedge clk);
    check_outputs();
    end_test("back_to_back");

    // walk one counter up to saturation and back one step
    predict(random_pc());
    t = pred_tag;
    for (int k = 1; k <= 5; k++) begin
      retire(t, k != 5, random_pc(), random_pc(), 1'b0);
      flush_only();
      predict(pc_for_idx(t.idx, random_pc()));
      check_val("pred_tag.idx", 32'(pred_tag.idx), 32'(t.idx));
      check_val("pred_tag.ctr", 32'(pred_tag.ctr),
                (k == 5) ? 32'd2 : ((k >= 3) ? 32'd3 : 32'(k)));
      t = pred_tag;
    end
    check_val("pred_taken", 32'(pred_taken), 32'd1);
    end_test("counter_saturation");

    // flush alone and then flush with a retire on the same edge
    repeat (4) predict(random_pc());
    flush_only();
    predict(random_pc());
    repeat (3) predict(random_pc());
    t = pred_tag;
    retire(t, 1'b1, random_pc(), random_pc(), 1'b1);
    predict(random_pc());
    retire(pred_tag, 1'b0, random_pc(), random_pc(), 1'b1);
    predict(random_pc());
    end_test("flush_recovery");

    // install and alias miss, a not-taken retire leaves the entry
    p1 = random_pc();
    tg = random_pc();
    retire('0, 1'b1, p1, tg, 1'b0);
    predict(p1);
    check_val("pred_hit", 32'(pred_hit), 32'd1);
    check_val("pred_target", 32'(pred_target), 32'(tg));
    p2 = p1;
    p2[btb_tag_msb:btb_tag_lsb] = ~p1[btb_tag_msb:btb_tag_lsb];
    predict(p2);
    check_val("pred_hit", 32'(pred_hit), 32'd0);
    retire('0, 1'b0, p1, random_pc(), 1'b0);
    predict(p1);
    check_val("pred_target", 32'(pred_target), 32'(tg));
    end_test("target_buffer");

    // read and write on one edge
    p1 = random_pc();
    t.idx = spec_m ^ p1[pht_idx_msb:pht_idx_lsb];
    t.ctr = ctr_t'(pht_m[t.idx]);
    tg = random_pc();
    operate(1'b1, p1, 1'b1, t, 1'b1, p1, tg, 1'b0);
    predict(p1);
    check_val("pred_target", 32'(pred_target), 32'(tg));
    flush_only();
    predict(pc_for_idx(t.idx, random_pc()));
    check_val("pred_tag.idx", 32'(pred_tag.idx), 32'(t.idx));
    end_test("same_cycle_rw");

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_ok + tests_bad, tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/bp_cfg_pkg.sv
logic/bp_types_pkg.sv
logic/bp_gshare.sv
logic/bp_btb.sv
logic/bp_unit.sv
tests/bp_clk_gen.sv
tests/bp_unit_chk.sv
tests/bp_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bp_unit_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) logic/*.sv tests/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
